// ==== flist.f ====
busPkg.sv
rhPkg.sv
edgeTrig.sv
rhDataBuf.sv
rhRegDecode.sv
rhStatus.sv
rhCtrl.sv
rhCtrlChecker.sv
rhCtrlTb.sv

// ==== Bender.yml ====
package:
  name: rh_ctrl

sources:
  - target: rtl
    files:
      - busPkg.sv
      - rhPkg.sv
      - edgeTrig.sv
      - rhDataBuf.sv
      - rhRegDecode.sv
      - rhStatus.sv
      - rhCtrl.sv
  - target: test
    files:
      - rhCtrlChecker.sv
      - rhCtrlTb.sv

// ==== rhCtrlTb.sv ====
//////////////////////////////
// RH11 controller testbench
// Clock, reset, DUT and checker, stimulus table
// applied in a loop with two idle cycles per access
//////////////////////////////

module rhCtrlTb
   import busPkg::*, rhPkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int bufDepth  = defaultBufDepth;
   localparam int goTimeout = 20;          // Cycles for rhGo to settle

   typedef enum logic [1:0] {opWr, opRd, opGo, opDevClr} opKind;   // opGo waits on rhGo

   typedef struct packed {
      logic [3:0]           test;
      opKind                op;
      logic [addrWidth-1:0] addr;
      logic [1:0]           lanes;         // {high, low}
      rhWord                data;          // GO level for opGo
      rhWord                want;          // Expected read value
      logic                 hasWant;
   } stimEntry;

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 devReset, devWrite, devRead, devLoByte, devHiByte;
   logic [addrWidth-1:0] devAddr;
   devWord               devDataI, devDataO;
   logic                 rhGo;
   rhWord                expWord;
   logic                 expValid;
   int                   errCount, checkCount;
   stimEntry             stim[$];
   rhWord                words[$];         // Written data still in the buffer

   always #5 clk = ~clk;

   rhCtrl #(.bufDepth(bufDepth)) u_dut (
      .clk(clk), .rst(rst), .devReset(devReset), .devWrite(devWrite),
      .devRead(devRead), .devAddr(devAddr), .devLoByte(devLoByte),
      .devHiByte(devHiByte), .devDataI(devDataI), .devDataO(devDataO), .rhGo(rhGo)
   );

   rhCtrlChecker #(.bufDepth(bufDepth)) u_check (
      .clk(clk), .rst(rst), .devReset(devReset), .devWrite(devWrite),
      .devRead(devRead), .devAddr(devAddr), .devLoByte(devLoByte),
      .devHiByte(devHiByte), .devDataI(devDataI), .devDataO(devDataO), .rhGo(rhGo),
      .expWord(expWord), .expValid(expValid), .errCount(errCount), .checkCount(checkCount)
   );

   //////////////////////////////
   // Table building
   //////////////////////////////

   task automatic addEntry(int test, opKind op, logic [addrWidth-1:0] addr,
                           logic [1:0] lanes, rhWord data, rhWord want, logic hasWant);
      stimEntry e;
      e.test    = test[3:0];
      e.op      = op;
      e.addr    = addr;
      e.lanes   = lanes;
      e.data    = data;
      e.want    = want;
      e.hasWant = hasWant;
      stim.push_back(e);
   endtask

   task automatic writeReg(int test, logic [addrWidth-1:0] addr, logic [1:0] lanes, rhWord d);
      addEntry(test, opWr, addr, lanes, d, '0, 1'b0);
   endtask

   task automatic readReg(int test, logic [addrWidth-1:0] addr, rhWord want);
      addEntry(test, opRd, addr, 2'b11, '0, want, 1'b1);
   endtask

   task automatic fillBuf(int test, int n);
      rhWord w;
      for (int k = 0; k < n; k++)
      begin
         w = rhWord'($urandom);
         words.push_back(w);
         writeReg(test, addrDb, 2'b11, w);
      end
   endtask

   task automatic drainBuf(int test, int n);
      for (int k = 0; k < n; k++)
         readReg(test, addrDb, words.pop_front());   // Same order as written
   endtask

   task automatic buildTable();
      readReg(1, addrSts, 16'h0040);                       // IR only after reset
      readReg(1, addrCs1, 16'h0000);
      addEntry(1, opGo, '0, 2'b00, 16'h0000, '0, 1'b0);
      fillBuf(2, 10);
      readReg(2, addrSts, 16'h00c0);
      drainBuf(2, 10);
      readReg(2, addrSts, 16'h0040);                       // OR back low
      fillBuf(3, bufDepth);
      readReg(3, addrSts, 16'h0080);                       // Full so IR dropped
      writeReg(3, addrDb, 2'b11, rhWord'($urandom));       // Overflow word
      readReg(3, addrSts, 16'h8080);
      drainBuf(3, bufDepth);
      readReg(3, addrSts, 16'h8040);
      writeReg(4, addrCs1, 2'b11, 16'h4000);               // Clear TRE
      readReg(4, addrSts, 16'h0040);
      addEntry(4, opRd, addrDb, 2'b11, '0, '0, 1'b0);      // Underflow returns a stale word
      readReg(4, addrSts, 16'h8040);
      fillBuf(4, 3);
      readReg(4, addrSts, 16'h80c0);
      writeReg(4, addrCs1, 2'b11, 16'h4001);               // Clear TRE with GO held high
      words.delete();                                      // Flushed
      readReg(4, addrSts, 16'h0040);
      writeReg(4, addrCs1, 2'b11, 16'h0000);               // GO back low
      writeReg(5, addrCs1, 2'b11, 16'h0001);               // GO
      addEntry(5, opGo, '0, 2'b00, 16'h0001, '0, 1'b0);
      readReg(5, addrCs1, 16'h0001);
      addEntry(5, opRd, addrDb, 2'b11, '0, '0, 1'b0);
      fillBuf(5, 2);
      readReg(5, addrSts, 16'h80c0);
      readReg(5, addrCs1, 16'h4001);                       // Late error in bit 14
      writeReg(5, addrCs1, 2'b11, 16'h0021);               // Controller clear beats GO
      words.delete();
      addEntry(5, opGo, '0, 2'b00, 16'h0000, '0, 1'b0);
      readReg(5, addrSts, 16'h0040);
      readReg(5, addrCs1, 16'h0000);
      writeReg(5, addrCs1, 2'b11, 16'h0001);               // GO again
      addEntry(5, opRd, addrDb, 2'b11, '0, '0, 1'b0);
      fillBuf(5, 2);
      readReg(5, addrCs1, 16'h4001);
      addEntry(5, opDevClr, '0, 2'b00, '0, '0, 1'b0);      // Device clear
      words.delete();
      addEntry(5, opGo, '0, 2'b00, 16'h0000, '0, 1'b0);
      readReg(5, addrSts, 16'h0040);
      readReg(5, addrCs1, 16'h0000);
      writeReg(6, addrWc, 2'b11, 16'h1234);
      readReg(6, addrWc, 16'h1234);
      writeReg(6, addrWc, 2'b01, 16'hffab);                // Low byte only
      readReg(6, addrWc, 16'h12ab);
      writeReg(6, addrWc, 2'b10, 16'hcdee);                // High byte only
      readReg(6, addrWc, 16'hcdab);
   endtask

   //////////////////////////////
   // Driving
   //////////////////////////////

   task automatic waitForGo(logic level, output bit ok);
      ok = 1'b0;
      for (int cyc = 0; cyc < goTimeout && !ok; cyc++)
      begin
         @(negedge clk);
         ok = (rhGo === level);
      end
      if (!ok)
         $display("rhGo did not reach %b within %0d cycles", level, goTimeout);
   endtask

   task automatic applyEntry(stimEntry e, output bit ok);
      ok = 1'b1;
      if (e.op == opGo)
         waitForGo(e.data[0], ok);
      else
      begin
         @(posedge clk);
         #1;
         devAddr   = e.addr;
         devLoByte = e.lanes[0];
         devHiByte = e.lanes[1];
         devDataI  = devWord'({{(devWidth - wordWidth){1'b0}}, e.data});
         expWord   = e.want;
         expValid  = e.hasWant;
         devWrite  = (e.op == opWr);
         devRead   = (e.op == opRd);
         devReset  = (e.op == opDevClr);   // One-cycle device clear
         @(posedge clk);
         #1;
         devWrite = 1'b0;                  // Strobe is one cycle
         devRead  = 1'b0;
         devReset = 1'b0;
         expValid = 1'b0;
         @(posedge clk);                   // Second idle cycle
      end
   endtask

   initial
   begin
      int prevErr;
      int i;
      bit ok;
      bit timedOut;
      void'($urandom(32'hc90a9df6));
      rst       = 1'b1;
      devReset  = 1'b0;
      devWrite  = 1'b0;
      devRead   = 1'b0;
      devAddr   = '0;
      devLoByte = 1'b0;
      devHiByte = 1'b0;
      devDataI  = '0;
      expWord   = '0;
      expValid  = 1'b0;
      buildTable();
      repeat (16) @(posedge clk);
      #1;
      rst      = 1'b0;
      prevErr  = 0;
      timedOut = 1'b0;
      for (i = 0; i < stim.size() && !timedOut; i++)
      begin
         applyEntry(stim[i], ok);
         timedOut = ~ok;
         if (timedOut || i == stim.size() - 1 || stim[i + 1].test != stim[i].test)
         begin
            $display("test %0d finished, %0d errors", stim[i].test, errCount - prevErr);
            prevErr = errCount;
         end
      end
      $display("%0d of %0d entries, %0d checks, %0d errors",
               i, stim.size(), checkCount, errCount);
      if (errCount == 0 && !timedOut)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== rhCtrlChecker.sv ====
//////////////////////////////
// RH11 controller checker
// Reference model of the data buffer and the status rules,
// compares every register read and the GO output
//////////////////////////////

module rhCtrlChecker
   import busPkg::*, rhPkg::*;
#(
   parameter int bufDepth = defaultBufDepth
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 devReset,
   input  logic                 devWrite,
   input  logic                 devRead,
   input  logic [addrWidth-1:0] devAddr,
   input  logic                 devLoByte,
   input  logic                 devHiByte,
   input  logic [devWidth-1:0]  devDataI,
   input  logic [devWidth-1:0]  devDataO,
   input  logic                 rhGo,
   input  rhWord                expWord,     // Table value for this read
   input  logic                 expValid,
   output int                   errCount,
   output int                   checkCount
);
   timeunit 1ns;
   timeprecision 1ps;

   rhWord fifo[$];                 // Buffer contents, head first
   rhWord modelWc  = '0;
   logic  modelGo  = 1'b0;
   logic  modelDlt = 1'b0;         // Sticky late error
   int    errs     = 0;
   int    checks   = 0;

   assign errCount   = errs;
   assign checkCount = checks;

   // Whole bus compared, upper bits must read zero
   task automatic compareBus(string name, logic [devWidth-1:0] got, rhWord want);
      logic [devWidth-1:0] wantBus;
      wantBus = {{(devWidth - wordWidth){1'b0}}, want};
      checks++;
      if (got !== wantBus)
      begin
         errs++;
         $display("ERR t=%0t %s got %h exp %h", $time, name, got, wantBus);
      end
   endtask

   //////////////////////////////
   // Model updates
   //////////////////////////////

   task automatic modelWrite(rhWord d);
      case (devAddr)
         addrCs1:
         begin
            modelGo = d[bitGo] & ~d[bitClr];            // Clear beats GO
            if (d[bitClr] | d[bitClrTre])
               modelDlt = 1'b0;
            if (d[bitClr] | d[bitClrTre] | ~d[bitGo])    // Every clear flushes
               fifo.delete();
         end
         addrWc:
         begin
            if (devLoByte)
               modelWc[7:0] = d[7:0];
            if (devHiByte)
               modelWc[15:8] = d[15:8];
         end
         addrDb:
            if (fifo.size() >= bufDepth)
               modelDlt = 1'b1;                          // Write dropped
            else
               fifo.push_back(d);
         default: ;
      endcase
   endtask

   task automatic modelRead();
      rhWord want;
      bit    known;
      want  = '0;
      known = 1'b1;
      case (devAddr)
         addrCs1:
         begin
            want[bitGo]     = modelGo;
            want[bitClrTre] = modelDlt;                  // Late error shows here
         end
         addrWc:  want = modelWc;
         addrSts:
         begin
            want[bitIr]  = (fifo.size() < bufDepth);
            want[bitOr]  = (fifo.size() != 0);
            want[bitDlt] = modelDlt;
         end
         addrDb:
            if (fifo.size() == 0)
            begin
               known    = 1'b0;                          // Stale word
               modelDlt = 1'b1;
            end
            else
               want = fifo.pop_front();
         default: ;
      endcase
      if (known)
         compareBus("devDataO", devDataO, want);
      if (expValid)
         compareBus("devDataO vs table", devDataO, expWord);
   endtask

   // Strobes are stable mid cycle
   always @(negedge clk)
   begin
      if (rst)
      begin
         fifo.delete();
         modelWc  = '0;
         modelGo  = 1'b0;
         modelDlt = 1'b0;
      end
      else
      begin
         if (rhGo !== modelGo)
         begin
            errs++;
            $display("ERR t=%0t rhGo got %b exp %b", $time, rhGo, modelGo);
         end
         if (devReset)
         begin
            fifo.delete();
            modelWc  = '0;
            modelGo  = 1'b0;
            modelDlt = 1'b0;
         end
         else if (devWrite)
            modelWrite(devDataI[wordWidth-1:0]);
         else if (devRead)
            modelRead();
      end
   end

endmodule

// ==== rhCtrl.sv ====
//////////////////////////////
// RH11 controller register slice
// Joins decoder, status registers and data buffer,
// returns register reads on the device bus
//////////////////////////////

module rhCtrl
   import busPkg::*, rhPkg::*;
#(
   parameter int bufDepth = defaultBufDepth
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 devReset,    // Device clear
   input  logic                 devWrite,
   input  logic                 devRead,
   input  logic [addrWidth-1:0] devAddr,
   input  logic                 devLoByte,
   input  logic                 devHiByte,
   input  devWord               devDataI,
   output devWord               devDataO,
   output logic                 rhGo
);

   rhWord      wrData;
   logic [1:0] byteEn;
   logic       dbWrite, dbRead, csWrite, wcWrite;
   logic       clr, clrTre, clrGo, devClear;
   logic       setDlt, bufIr, bufOr, dltFlag;
   logic       flush;                 // Any clear empties the buffer
   rhWord      dbData, csValue, wcValue;
   rhWord      stsValue;
   rhWord      rdWord;                // Selected register

   rhRegDecode u_decode (
      .devWrite (devWrite),   .devRead (devRead),   .devAddr (devAddr),
      .devLoByte(devLoByte),  .devHiByte(devHiByte), .devDataI(devDataI),
      .devReset (devReset),   .wrData  (wrData),    .byteEn  (byteEn),
      .dbWrite  (dbWrite),    .dbRead  (dbRead),    .csWrite (csWrite),
      .wcWrite  (wcWrite),    .clr     (clr),       .clrTre  (clrTre),
      .clrGo    (clrGo),      .devClear(devClear)
   );

   rhStatus u_status (
      .clk    (clk),     .rst     (rst),      .csWrite(csWrite),
      .wcWrite(wcWrite), .byteEn  (byteEn),   .wrData (wrData),
      .clr    (clr),     .clrTre  (clrTre),   .clrGo  (clrGo),
      .devClear(devClear), .setDlt(setDlt),   .csValue(csValue),
      .wcValue(wcValue), .dltFlag (dltFlag),  .rhGo   (rhGo)
   );

   assign flush = clr | clrTre | clrGo | devClear;

   rhDataBuf #(.bufDepth(bufDepth)) u_dataBuf (
      .clk    (clk),     .rst    (rst),     .flush (flush),
      .dbWrite(dbWrite), .dbRead (dbRead),  .wrData(wrData),
      .dbData (dbData),  .setDlt (setDlt),  .bufIr (bufIr),
      .bufOr  (bufOr)
   );

   //////////////////////////////
   // Read path
   //////////////////////////////

   always_comb
   begin
      stsValue         = '0;
      stsValue[bitIr]  = bufIr;
      stsValue[bitOr]  = bufOr;
      stsValue[bitDlt] = dltFlag;
   end

   always_comb
   begin
      case (devAddr)
         addrCs1: rdWord = csValue;
         addrWc:  rdWord = wcValue;
         addrDb:  rdWord = dbData;        // Head word
         addrSts: rdWord = stsValue;
         default: rdWord = '0;            // Unused selects read zero
      endcase
   end

   // Upper bits zero, back to big-endian numbering
   assign devDataO = leToDev({{(devWidth-wordWidth){1'b0}}, rdWord});

endmodule

// ==== rhStatus.sv ====
//////////////////////////////
// RH11 control and status
// GO bit, sticky data-late flag and word count register
//////////////////////////////

module rhStatus
   import busPkg::*, rhPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       csWrite,
   input  logic       wcWrite,
   input  logic [1:0] byteEn,     // {high, low}
   input  rhWord      wrData,
   input  logic       clr,
   input  logic       clrTre,
   input  logic       clrGo,
   input  logic       devClear,
   input  logic       setDlt,     // From the data buffer
   output rhWord      csValue,    // CS1 read value
   output rhWord      wcValue,
   output logic       dltFlag,
   output logic       rhGo        // To the drive side
);

   //////////////////////////////
   // GO and data late
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rhGo    <= 1'b0;
         dltFlag <= 1'b0;
      end
      else
      begin
         // Clears win over sets
         if (clr | clrGo | devClear)
            rhGo <= 1'b0;
         else if (csWrite & wrData[bitGo])
            rhGo <= 1'b1;

         if (clr | clrTre | devClear)
            dltFlag <= 1'b0;
         else if (setDlt)
            dltFlag <= 1'b1;              // Sticky
      end
   end

   //////////////////////////////
   // Word count
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         wcValue <= '0;
      else if (devClear)
         wcValue <= '0;
      else if (wcWrite)
         wcValue <= mergeLanes(wcValue, wrData, byteEn);   // Other byte kept
   end

   // Late error reads back in the TRE position
   always_comb
   begin
      csValue            = '0;
      csValue[bitGo]     = rhGo;
      csValue[bitClrTre] = dltFlag;
   end

endmodule

// ==== rhRegDecode.sv ====
//////////////////////////////
// RH11 register decoder
// Turns device bus strobes and the register select into
// per-register strobes and CS1 clear commands
//////////////////////////////

module rhRegDecode
   import busPkg::*, rhPkg::*;
(
   input  logic                 devWrite,    // One-cycle write strobe
   input  logic                 devRead,     // One-cycle read strobe
   input  logic [addrWidth-1:0] devAddr,
   input  logic                 devLoByte,
   input  logic                 devHiByte,
   input  devWord               devDataI,    // Big-endian numbering
   input  logic                 devReset,
   output rhWord                wrData,      // Register field, usual order
   output logic [1:0]           byteEn,      // {high, low}
   output logic                 dbWrite,
   output logic                 dbRead,
   output logic                 csWrite,
   output logic                 wcWrite,
   output logic                 clr,         // Controller clear
   output logic                 clrTre,      // Transfer error clear
   output logic                 clrGo,       // CS1 written with GO low
   output logic                 devClear
);

   logic [devWidth-1:0] dataLe;     // Bus after the swap
   logic                selCs1;
   logic                selWc;
   logic                selDb;

   //////////////////////////////
   // Data path
   //////////////////////////////

   assign dataLe = devToLe(devDataI);
   assign wrData = regField(dataLe);
   assign byteEn = {devHiByte, devLoByte};   // Both set is a full word

   //////////////////////////////
   // Address compare
   //////////////////////////////

   assign selCs1 = (devAddr == addrCs1);
   assign selWc  = (devAddr == addrWc);
   assign selDb  = (devAddr == addrDb);
   // Status word has no write side effects

   // All combinational, so each falls with the bus strobe
   assign dbWrite = devWrite & selDb;
   assign dbRead  = devRead & selDb;
   assign csWrite = devWrite & selCs1;
   assign wcWrite = devWrite & selWc;

   //////////////////////////////
   // CS1 commands
   //////////////////////////////

   assign clr      = csWrite & wrData[bitClr];
   assign clrTre   = csWrite & wrData[bitClrTre];
   assign clrGo    = csWrite & ~wrData[bitGo];
   assign devClear = devReset;               // Straight through

endmodule

// ==== rhDataBuf.sv ====
//////////////////////////////
// RH11 data buffer
// Circular word store with depth count, wrapping pointers
// and device-late detection, pointers move on strobe fall
//////////////////////////////

module rhDataBuf
   import busPkg::*, rhPkg::*;
#(
   parameter int bufDepth = defaultBufDepth   // Full at this many words
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  flush,            // Empties the buffer
   input  logic  dbWrite,          // Bus write strobe
   input  logic  dbRead,           // Bus read strobe
   input  rhWord wrData,
   output rhWord dbData,           // Head word, registered
   output logic  setDlt,           // Late access this cycle
   output logic  bufIr,            // Room for a write
   output logic  bufOr             // Word waiting
);

   logic                wrFall;    // Write strobe just dropped
   logic                rdFall;    // Read strobe just dropped
   logic [ptrWidth-1:0] depth;     // Words held
   logic [ptrWidth-1:0] rdPtr;
   logic [ptrWidth-1:0] wrPtr;
   logic                empty;
   logic                full;
   rhWord               mem [bufStore];

   //////////////////////////////
   // Strobe edges
   //////////////////////////////

   edgeTrig #(.posEdge(1'b0)) u_wrEdge (
      .clk   (clk),
      .rst   (rst),
      .sig   (dbWrite),
      .pulse (wrFall)
   );

   edgeTrig #(.posEdge(1'b0)) u_rdEdge (
      .clk   (clk),
      .rst   (rst),
      .sig   (dbRead),
      .pulse (rdFall)
   );

   assign empty = (depth == '0);
   assign full  = (depth == ptrWidth'(bufDepth));

   //////////////////////////////
   // Pointers and depth
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         depth <= '0;
         rdPtr <= '0;
         wrPtr <= '0;
      end
      else if (flush)
      begin
         depth <= '0;
         rdPtr <= '0;
         wrPtr <= '0;
      end
      else if (rdFall & ~wrFall & ~empty)
      begin
         depth <= depth - 1'b1;
         rdPtr <= rdPtr + 1'b1;          // Wraps 127 to 0
      end
      else if (wrFall & ~rdFall & ~full)
      begin
         depth <= depth + 1'b1;
         wrPtr <= wrPtr + 1'b1;
      end
      // Both edges at once leave the pointers alone
   end

   //////////////////////////////
   // Store
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (dbWrite & ~full)
         mem[wrPtr] <= wrData;           // Dropped when full
      dbData <= mem[rdPtr];              // Follows the head every cycle
   end

   // Late on read of empty or write to full
   assign setDlt = (empty & dbRead) | (full & dbWrite);
   assign bufIr  = ~full;
   assign bufOr  = ~empty;

endmodule

// ==== edgeTrig.sv ====
//////////////////////////////
// Edge trigger
// One-cycle pulse on the rising or falling edge of a strobe
//////////////////////////////

module edgeTrig #(
   parameter bit posEdge = 1'b1    // 1 rising, 0 falling
) (
   input  logic clk,
   input  logic rst,
   input  logic sig,               // Strobe being watched
   output logic pulse              // One cycle wide
);

   logic sigDly;                   // Level seen last cycle

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         sigDly <= 1'b0;
      else
         sigDly <= sig;
   end

   // Pulse lands in the cycle after the transition
   always_comb
   begin
      if (posEdge)
         pulse = sig & ~sigDly;
      else
         pulse = ~sig & sigDly;
   end

endmodule

// ==== rhPkg.sv ====
//////////////////////////////
// RH11 register map
// Register addresses, CS1 and status bit positions,
// data buffer sizes
//////////////////////////////

package rhPkg;

   import busPkg::*;

   //////////////////////////////
   // Register addresses
   //////////////////////////////

   localparam logic [addrWidth-1:0] addrCs1 = 3'd0;   // Control and status 1
   localparam logic [addrWidth-1:0] addrWc  = 3'd1;   // Word count
   localparam logic [addrWidth-1:0] addrDb  = 3'd2;   // Data buffer
   localparam logic [addrWidth-1:0] addrSts = 3'd3;   // Buffer status, read only

   //////////////////////////////
   // CS1 bits
   //////////////////////////////

   localparam int bitGo     = 0;    // GO, read and write
   localparam int bitClr    = 5;    // Controller clear, write only
   localparam int bitClrTre = 14;   // Write clears TRE, reads as the late error

   //////////////////////////////
   // Status word bits
   //////////////////////////////

   localparam int bitIr  = 6;       // Input ready
   localparam int bitOr  = 7;       // Output ready
   localparam int bitDlt = 15;      // Data late

   // Data buffer sizing
   localparam int defaultBufDepth = 66;    // Words held before full
   localparam int bufStore        = 128;   // Words of RAM behind it
   localparam int ptrWidth        = 7;     // Wraps at bufStore

endpackage

// ==== busPkg.sv ====
//////////////////////////////
// Device bus definitions
// Widths of the 36-bit device bus and the 16-bit controller
// registers, bit order swap and byte-lane helpers
//////////////////////////////

package busPkg;

   localparam int devWidth  = 36;   // Device bus word
   localparam int wordWidth = 16;   // Controller register
   localparam int addrWidth = 3;    // Register select

   // Bus is numbered from 0 at the MSB
   typedef logic [0:devWidth-1]  devWord;
   typedef logic [wordWidth-1:0] rhWord;

   // Renumber the bus into the usual order, MSB stays MSB
   function automatic logic [devWidth-1:0] devToLe(devWord d);
      return d;
   endfunction

   // Back to bus numbering for the read path
   function automatic devWord leToDev(logic [devWidth-1:0] w);
      return w;
   endfunction

   // Register field sits in the low 16 bits of the swapped word
   function automatic rhWord regField(logic [devWidth-1:0] w);
      return w[wordWidth-1:0];
   endfunction

   // Replace only the enabled lanes, lanes[1] high byte, lanes[0] low byte
   function automatic rhWord mergeLanes(rhWord oldW, rhWord newW, logic [1:0] lanes);
      rhWord res;
      res = oldW;
      if (lanes[0])
         res[7:0] = newW[7:0];
      if (lanes[1])
         res[15:8] = newW[15:8];
      return res;
   endfunction

endpackage
